//--- Bender.yml
package:
  name: mips_pipe

sources:
  - rtl/mips_pkg.sv
  - rtl/pipe_if.sv
  - rtl/stage_if.sv
  - rtl/stage_id.sv
  - rtl/stage_ex.sv
  - rtl/stage_mem.sv
  - rtl/mips_top.sv
  - target: simulation
    files:
      - bench/tb_clock.sv
      - bench/tb_checker.sv
      - bench/tb_mips.sv

//--- bench/tb_checker.sv
`timescale 1ns/1ps

module tb_checker (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 debug_flag,
	input  logic                 imem_we,
	input  mips_pkg::imem_addr_t imem_addr,
	input  mips_pkg::data_t      imem_data,
	input  mips_pkg::reg_addr_t  dbg_reg_addr,
	input  mips_pkg::data_t      dbg_reg_data,
	input  mips_pkg::pc_t        out_pc,
	input  logic                 halt_flag,
	input  logic                 sweep,
	output int                   reg_errors,
	output int                   ctrl_errors
);

	// copy of the instruction ram, taken off the debug port
	mips_pkg::data_t prog [mips_pkg::len_imem];
	// architectural state of the reference model
	mips_pkg::data_t model_rf [mips_pkg::num_regs];
	mips_pkg::data_t model_dmem [mips_pkg::len_dmem];
	logic            model_ready;
	logic            was_in_reset;
	logic            halt_high;

	initial begin
		reg_errors   = 0;
		ctrl_errors  = 0;
		model_ready  = 1'b0;
		was_in_reset = 1'b0;
		halt_high    = 1'b0;
	end

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////

	// program order, one instruction per step, no delay slots
	task automatic run_model();
		int              pc;
		int              pc_next;
		int              steps;
		mips_pkg::data_t w;
		mips_pkg::data_t a;
		mips_pkg::data_t b;
		mips_pkg::data_t imm;
		mips_pkg::data_t addr;
		for (int i = 0; i < mips_pkg::num_regs; i++)
			model_rf[i] = '0;
		for (int i = 0; i < mips_pkg::len_dmem; i++)
			model_dmem[i] = '0;
		pc    = 0;
		steps = 0;
		while (pc >= 0 && pc < mips_pkg::len_imem && steps < 1000 &&
			prog[pc] !== mips_pkg::halt_word) begin
			w       = prog[pc];
			a       = model_rf[w[25:21]];
			b       = model_rf[w[20:16]];
			imm     = {{16{w[15]}}, w[15:0]};
			// byte address, one word per 4 bytes
			addr    = a + imm;
			pc_next = pc + 1;
			case (w[31:26])
				mips_pkg::op_rtype: begin
					case (w[5:0])
						mips_pkg::fn_addu: model_rf[w[15:11]] = a + b;
						mips_pkg::fn_subu: model_rf[w[15:11]] = a - b;
						mips_pkg::fn_and:  model_rf[w[15:11]] = a & b;
						mips_pkg::fn_or:   model_rf[w[15:11]] = a | b;
						mips_pkg::fn_slt:  model_rf[w[15:11]] = ($signed(a) < $signed(b)) ? 1 : 0;
						default: ;
					endcase
				end
				mips_pkg::op_addi: model_rf[w[20:16]] = a + imm;
				mips_pkg::op_lw:   model_rf[w[20:16]] = model_dmem[int'((addr >> 2) % mips_pkg::len_dmem)];
				mips_pkg::op_sw:   model_dmem[int'((addr >> 2) % mips_pkg::len_dmem)] = b;
				// offset counts words from the next instruction
				mips_pkg::op_beq: begin
					if (a == b)
						pc_next = pc + 1 + int'($signed(imm));
				end
				// target field is an absolute word index
				mips_pkg::op_j: pc_next = int'(w[25:0]);
				default: ;
			endcase
			// r0 hardwired
			model_rf[0] = '0;
			pc          = pc_next;
			steps++;
		end
		if (pc < 0 || pc >= mips_pkg::len_imem || steps >= 1000) begin
			ctrl_errors++;
			$display("The reference model ran off the program without reaching HALT.");
		end
		model_ready = 1'b1;
	endtask

	////////////////////////////////////////
	// monitor
	////////////////////////////////////////

	always @(posedge clk) begin
		// first edge after reset, outputs must be idle
		if (was_in_reset && rst_n) begin
			if (halt_flag !== 1'b0) begin
				ctrl_errors++;
				$display("** Error at %0t ns: halt_flag is %b after reset, expected 0",
					$time, halt_flag);
			end
			if (out_pc !== '0) begin
				ctrl_errors++;
				$display("** Error at %0t ns: out_pc is %0d after reset, expected 0",
					$time, out_pc);
			end
		end
		// mirror every debug write
		if (rst_n && debug_flag && imem_we)
			prog[imem_addr] = imem_data;
		// halt_flag rises once per run, then sticks
		if (!rst_n) begin
			halt_high   = 1'b0;
			model_ready = 1'b0;
		end else if (halt_flag) begin
			if (!halt_high) begin
				run_model();
				halt_high = 1'b1;
			end
		end else if (halt_high) begin
			ctrl_errors++;
			halt_high = 1'b0;
			$display("** Error at %0t ns: halt_flag fell back to 0 before reset", $time);
		end
		// register readback against the model
		if (sweep) begin
			if (!model_ready) begin
				reg_errors++;
				$display("Registers were read back before the program had halted.");
			end else if (dbg_reg_data !== model_rf[dbg_reg_addr]) begin
				reg_errors++;
				$display("** Error at %0t ns: r%0d expected %08h, actual %08h",
					$time, dbg_reg_addr, model_rf[dbg_reg_addr], dbg_reg_data);
			end
		end
		was_in_reset = !rst_n;
	end

endmodule

//--- bench/tb_clock.sv
`timescale 1ns/1ps

// free-running clock plus power-on reset
module tb_clock (
	output logic clk,
	output logic rst_n
);

	// 10 ns period
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// low over the first 4 rising edges, let go on a falling edge
	initial begin
		rst_n = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

//--- bench/tb_mips.sv
`timescale 1ns/1ps

module tb_mips;

	localparam int num_runs     = 20;
	localparam int prog_len     = 32;
	localparam int halt_timeout = 2000;

	logic                 clk;
	logic                 por_n;
	logic                 run_rst_n;
	logic                 rst_n;
	logic                 debug_flag;
	mips_pkg::imem_addr_t imem_addr;
	mips_pkg::data_t      imem_data;
	logic                 imem_we;
	mips_pkg::reg_addr_t  dbg_reg_addr;
	mips_pkg::data_t      dbg_reg_data;
	mips_pkg::pc_t        out_pc;
	logic                 halt_flag;
	logic                 sweep;
	int                   reg_errors;
	int                   ctrl_errors;
	int                   timeouts;
	logic                 timed_out;
	logic                 halted;
	int                   cyc;
	// random program plus the closing halt word
	mips_pkg::data_t      prog [prog_len + 1];

	tb_clock clock_gen (
		.clk   (clk),
		.rst_n (por_n)
	);

	// power-on reset and the per-run pulse
	assign rst_n = por_n && run_rst_n;

	mips_top mips_top_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.debug_flag   (debug_flag),
		.imem_addr    (imem_addr),
		.imem_data    (imem_data),
		.imem_we      (imem_we),
		.dbg_reg_addr (dbg_reg_addr),
		.dbg_reg_data (dbg_reg_data),
		.out_pc       (out_pc),
		.halt_flag    (halt_flag)
	);

	tb_checker check_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.debug_flag   (debug_flag),
		.imem_we      (imem_we),
		.imem_addr    (imem_addr),
		.imem_data    (imem_data),
		.dbg_reg_addr (dbg_reg_addr),
		.dbg_reg_data (dbg_reg_data),
		.out_pc       (out_pc),
		.halt_flag    (halt_flag),
		.sweep        (sweep),
		.reg_errors   (reg_errors),
		.ctrl_errors  (ctrl_errors)
	);

	////////////////////////////////////////
	// instruction encoding
	////////////////////////////////////////

	function automatic mips_pkg::data_t rtype_word(input mips_pkg::reg_addr_t rs,
		input mips_pkg::reg_addr_t rt, input mips_pkg::reg_addr_t rd, input mips_pkg::fn_t fn);
		return {mips_pkg::op_rtype, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic mips_pkg::data_t itype_word(input mips_pkg::op_t op,
		input mips_pkg::reg_addr_t rs, input mips_pkg::reg_addr_t rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic mips_pkg::data_t jump_word(input int target);
		return {mips_pkg::op_j, 26'(target)};
	endfunction

	// half the time reuse the last destination, for forwarding and load-use
	function automatic mips_pkg::reg_addr_t pick_src(input mips_pkg::reg_addr_t last);
		if ($urandom_range(0, 1) == 1)
			return last;
		return mips_pkg::reg_addr_t'($urandom_range(0, 31));
	endfunction

	task automatic build_program();
		int                  kind;
		int                  span;
		mips_pkg::reg_addr_t last;
		mips_pkg::reg_addr_t rs;
		mips_pkg::reg_addr_t rt;
		mips_pkg::reg_addr_t rd;
		mips_pkg::fn_t       fn;
		last = '0;
		for (int i = 0; i < prog_len; i++) begin
			kind = $urandom_range(0, 15);
			rs   = pick_src(last);
			rt   = pick_src(last);
			rd   = mips_pkg::reg_addr_t'($urandom_range(0, 31));
			// short forward reach keeps most of the program live
			span = (prog_len - 1 - i < 4) ? prog_len - 1 - i : 4;
			if (kind < 5) begin
				case ($urandom_range(0, 4))
					0: fn = mips_pkg::fn_addu;
					1: fn = mips_pkg::fn_subu;
					2: fn = mips_pkg::fn_and;
					3: fn = mips_pkg::fn_or;
					default: fn = mips_pkg::fn_slt;
				endcase
				prog[i] = rtype_word(rs, rt, rd, fn);
				last    = rd;
			end else if (kind < 8) begin
				prog[i] = itype_word(mips_pkg::op_addi, rs, rd, 16'($urandom_range(0, 16'hffff)));
				last    = rd;
			end else if (kind < 10) begin
				// base r0, word aligned
				prog[i] = itype_word(mips_pkg::op_lw, '0, rd,
					16'(4 * $urandom_range(0, mips_pkg::len_dmem - 1)));
				last    = rd;
			end else if (kind < 12) begin
				prog[i] = itype_word(mips_pkg::op_sw, '0, rt,
					16'(4 * $urandom_range(0, mips_pkg::len_dmem - 1)));
			end else if (kind < 15) begin
				// equal operands now and then so more branches are taken
				if ($urandom_range(0, 2) == 0)
					rt = rs;
				prog[i] = itype_word(mips_pkg::op_beq, rs, rt, 16'($urandom_range(0, span)));
			end else begin
				prog[i] = jump_word($urandom_range(i + 1, i + 1 + span));
			end
		end
		prog[prog_len] = mips_pkg::halt_word;
	endtask

	////////////////////////////////////////
	// run control
	////////////////////////////////////////

	// one word per cycle while fetch is parked
	task automatic load_program();
		debug_flag = 1'b1;
		for (int i = 0; i <= prog_len; i++) begin
			imem_addr = mips_pkg::imem_addr_t'(i);
			imem_data = prog[i];
			imem_we   = 1'b1;
			@(negedge clk);
		end
		imem_we    = 1'b0;
		debug_flag = 1'b0;
	endtask

	task automatic wait_for_halt(output logic seen);
		int n;
		n = 0;
		while (!halt_flag && n < halt_timeout) begin
			@(negedge clk);
			n++;
		end
		seen = halt_flag;
	endtask

	// one register per cycle, compared by the checker on the rising edge
	task automatic read_back_registers();
		for (int r = 0; r < mips_pkg::num_regs; r++) begin
			dbg_reg_addr = mips_pkg::reg_addr_t'(r);
			sweep        = 1'b1;
			@(negedge clk);
		end
		sweep = 1'b0;
	endtask

	// debug_flag stays high so fetch waits for the next load
	task automatic pulse_reset();
		debug_flag = 1'b1;
		run_rst_n  = 1'b0;
		repeat (4) @(negedge clk);
		run_rst_n  = 1'b1;
	endtask

	initial begin
		run_rst_n    = 1'b1;
		debug_flag   = 1'b1;
		imem_addr    = '0;
		imem_data    = '0;
		imem_we      = 1'b0;
		dbg_reg_addr = '0;
		sweep        = 1'b0;
		timeouts     = 0;
		timed_out    = 1'b0;
		void'($urandom(32'h8b47_3e74));

		// power-on reset from the clock module
		cyc = 0;
		while (!rst_n && cyc < 50) begin
			@(negedge clk);
			cyc++;
		end
		if (!rst_n) begin
			$display("Power-on reset was never released.");
			timeouts++;
			timed_out = 1'b1;
		end

		for (int run = 0; run < num_runs && !timed_out; run++) begin
			if (run > 0)
				pulse_reset();
			build_program();
			load_program();
			wait_for_halt(halted);
			if (!halted) begin
				$display("Run %0d did not raise halt_flag within %0d cycles.", run, halt_timeout);
				timeouts++;
				timed_out = 1'b1;
			end else begin
				read_back_registers();
			end
		end

		$display("error counts: register %0d, control %0d, timeout %0d",
			reg_errors, ctrl_errors, timeouts);
		if (reg_errors + ctrl_errors + timeouts == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

//--- rtl/mips_pkg.sv
package mips_pkg;

	////////////////////////////////////////
	// widths
	////////////////////////////////////////

	typedef logic [31:0] data_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [6:0]  imem_addr_t;
	// pc counts words, not bytes
	typedef logic [7:0]  pc_t;
	typedef logic [5:0]  op_t;
	typedef logic [5:0]  fn_t;
	typedef logic [2:0]  alu_op_t;

	// memory depths
	localparam int len_imem = 2 ** $bits(imem_addr_t);
	localparam int len_dmem = 32;
	localparam int dmem_aw  = $clog2(len_dmem);
	localparam int num_regs = 2 ** $bits(reg_addr_t);

	////////////////////////////////////////
	// encodings
	////////////////////////////////////////

	// primary opcodes
	localparam op_t op_rtype = 6'h00;
	localparam op_t op_j     = 6'h02;
	localparam op_t op_beq   = 6'h04;
	localparam op_t op_addi  = 6'h08;
	localparam op_t op_lw    = 6'h23;
	localparam op_t op_sw    = 6'h2b;

	// r-type funct field
	localparam fn_t fn_addu = 6'h21;
	localparam fn_t fn_subu = 6'h23;
	localparam fn_t fn_and  = 6'h24;
	localparam fn_t fn_or   = 6'h25;
	localparam fn_t fn_slt  = 6'h2a;

	// stops the machine once it reaches mem
	localparam data_t halt_word = 32'hffff_ffff;

	// alu operations
	localparam alu_op_t alu_add = 3'd0;
	localparam alu_op_t alu_sub = 3'd1;
	localparam alu_op_t alu_and = 3'd2;
	localparam alu_op_t alu_or  = 3'd3;
	localparam alu_op_t alu_slt = 3'd4;

	// fetch control
	typedef enum logic [1:0] {
		st_load,
		st_run,
		st_halted
	} fetch_state_t;

endpackage

//--- rtl/mips_top.sv
`timescale 1ns/1ps

module mips_top (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 debug_flag,
	input  mips_pkg::imem_addr_t imem_addr,
	input  mips_pkg::data_t      imem_data,
	input  logic                 imem_we,
	input  mips_pkg::reg_addr_t  dbg_reg_addr,
	output mips_pkg::data_t      dbg_reg_data,
	output mips_pkg::pc_t        out_pc,
	output logic                 halt_flag
);

	// if <-> id
	mips_pkg::data_t     instr;
	mips_pkg::pc_t       pc_plus4;
	logic                stall;
	logic                jump;
	mips_pkg::pc_t       jump_target;

	// mem -> if, and the flush to id and ex
	logic                branch_taken;
	mips_pkg::pc_t       branch_target;
	logic                halt_seen;

	// ex -> id hazard check
	logic                ex_mem_read;
	mips_pkg::reg_addr_t ex_dest;

	////////////////////////////////////////
	// stage registers
	////////////////////////////////////////

	id_ex_if  id_ex ();
	ex_mem_if ex_mem ();
	mem_wb_if mem_wb ();

	stage_if u_if (
		.clk           (clk),
		.rst_n         (rst_n),
		.debug_flag    (debug_flag),
		.imem_addr     (imem_addr),
		.imem_data     (imem_data),
		.imem_we       (imem_we),
		.stall         (stall),
		.jump          (jump),
		.jump_target   (jump_target),
		.branch_taken  (branch_taken),
		.branch_target (branch_target),
		.halt_seen     (halt_seen),
		.instr         (instr),
		.pc_plus4      (pc_plus4),
		.out_pc        (out_pc)
	);

	stage_id u_id (
		.clk          (clk),
		.rst_n        (rst_n),
		.instr        (instr),
		.pc_plus4     (pc_plus4),
		.flush        (branch_taken),
		.wb           (mem_wb.sink),
		.dbg_reg_addr (dbg_reg_addr),
		.ex_mem_read  (ex_mem_read),
		.ex_dest      (ex_dest),
		.stall        (stall),
		.jump         (jump),
		.jump_target  (jump_target),
		.dbg_reg_data (dbg_reg_data),
		.out          (id_ex.source)
	);

	// ex/mem doubles as the mem forwarding source
	stage_ex u_ex (
		.clk         (clk),
		.rst_n       (rst_n),
		.flush       (branch_taken),
		.in          (id_ex.sink),
		.fwd_mem     (ex_mem.source),
		.fwd_wb      (mem_wb.sink),
		.ex_mem_read (ex_mem_read),
		.ex_dest     (ex_dest)
	);

	stage_mem u_mem (
		.clk           (clk),
		.rst_n         (rst_n),
		.in            (ex_mem.sink),
		.out           (mem_wb.source),
		.branch_taken  (branch_taken),
		.branch_target (branch_target),
		.halt_seen     (halt_seen),
		.halt_flag     (halt_flag)
	);

endmodule

//--- rtl/pipe_if.sv
`timescale 1ns/1ps

// decode to execute
interface id_ex_if;
	mips_pkg::data_t     rs_val;
	mips_pkg::data_t     rt_val;
	mips_pkg::data_t     imm;
	mips_pkg::reg_addr_t rs, rt, dest;
	mips_pkg::alu_op_t   alu_op;
	logic                alu_src_imm;
	logic                mem_read, mem_write, reg_write, mem_to_reg;
	logic                is_branch, halt;
	mips_pkg::pc_t       pc_plus4;

	modport source (output rs_val, rt_val, imm, rs, rt, dest, alu_op, alu_src_imm,
		mem_read, mem_write, reg_write, mem_to_reg, is_branch, halt, pc_plus4);
	modport sink (input rs_val, rt_val, imm, rs, rt, dest, alu_op, alu_src_imm,
		mem_read, mem_write, reg_write, mem_to_reg, is_branch, halt, pc_plus4);
endinterface

// execute to memory, also the first forwarding source
interface ex_mem_if;
	mips_pkg::data_t     alu_result;
	mips_pkg::data_t     store_val;
	mips_pkg::pc_t       branch_target;
	logic                zero;
	mips_pkg::reg_addr_t dest;
	logic                mem_read, mem_write, reg_write, mem_to_reg;
	logic                is_branch, halt;

	modport source (output alu_result, store_val, branch_target, zero, dest,
		mem_read, mem_write, reg_write, mem_to_reg, is_branch, halt);
	modport sink (input alu_result, store_val, branch_target, zero, dest,
		mem_read, mem_write, reg_write, mem_to_reg, is_branch, halt);
endinterface

// write-back, read by the register file and by forwarding
interface mem_wb_if;
	logic                reg_write;
	mips_pkg::reg_addr_t dest;
	mips_pkg::data_t     wb_data;

	modport source (output reg_write, dest, wb_data);
	modport sink (input reg_write, dest, wb_data);
endinterface

//--- rtl/stage_ex.sv
`timescale 1ns/1ps

module stage_ex (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                flush,
	id_ex_if.sink               in,
	ex_mem_if.source            fwd_mem,
	mem_wb_if.sink              fwd_wb,
	output logic                ex_mem_read,
	output mips_pkg::reg_addr_t ex_dest
);

	mips_pkg::data_t op_a;
	mips_pkg::data_t rt_fwd;
	mips_pkg::data_t op_b;
	mips_pkg::data_t alu_y;

	// mem wins over wb, r0 never forwarded
	function automatic mips_pkg::data_t fwd(input mips_pkg::reg_addr_t r,
		input mips_pkg::data_t v);
		if (fwd_mem.reg_write && fwd_mem.dest != '0 && fwd_mem.dest == r)
			return fwd_mem.alu_result;
		if (fwd_wb.reg_write && fwd_wb.dest != '0 && fwd_wb.dest == r)
			return fwd_wb.wb_data;
		return v;
	endfunction

	////////////////////////////////////////
	// forwarding and alu
	////////////////////////////////////////

	always_comb begin
		op_a   = fwd(in.rs, in.rs_val);
		rt_fwd = fwd(in.rt, in.rt_val);
	end

	assign op_b = in.alu_src_imm ? in.imm : rt_fwd;

	always_comb begin
		case (in.alu_op)
			mips_pkg::alu_add: alu_y = op_a + op_b;
			mips_pkg::alu_sub: alu_y = op_a - op_b;
			mips_pkg::alu_and: alu_y = op_a & op_b;
			mips_pkg::alu_or:  alu_y = op_a | op_b;
			mips_pkg::alu_slt: alu_y = mips_pkg::data_t'($signed(op_a) < $signed(op_b));
			default:           alu_y = '0;
		endcase
	end

	// hazard info for decode
	assign ex_mem_read = in.mem_read;
	assign ex_dest     = in.dest;

	// ex/mem controls, a halt already here holds
	always_ff @(posedge clk) begin
		if (!rst_n || flush) begin
			fwd_mem.dest       <= '0;
			fwd_mem.mem_read   <= 1'b0;
			fwd_mem.mem_write  <= 1'b0;
			fwd_mem.reg_write  <= 1'b0;
			fwd_mem.mem_to_reg <= 1'b0;
			fwd_mem.is_branch  <= 1'b0;
			fwd_mem.halt       <= 1'b0;
		end else if (!fwd_mem.halt) begin
			fwd_mem.dest       <= in.dest;
			fwd_mem.mem_read   <= in.mem_read;
			fwd_mem.mem_write  <= in.mem_write;
			fwd_mem.reg_write  <= in.reg_write;
			fwd_mem.mem_to_reg <= in.mem_to_reg;
			fwd_mem.is_branch  <= in.is_branch;
			fwd_mem.halt       <= in.halt;
		end
	end

	// ex/mem payload
	always_ff @(posedge clk) begin
		if (!fwd_mem.halt) begin
			fwd_mem.alu_result    <= alu_y;
			fwd_mem.store_val     <= rt_fwd;
			// word offset relative to pc+1
			fwd_mem.branch_target <= in.pc_plus4 + mips_pkg::pc_t'(in.imm);
			fwd_mem.zero          <= alu_y == '0;
		end
	end

endmodule

//--- rtl/stage_id.sv
`timescale 1ns/1ps

module stage_id (
	input  logic                clk,
	input  logic                rst_n,
	input  mips_pkg::data_t     instr,
	input  mips_pkg::pc_t       pc_plus4,
	input  logic                flush,
	mem_wb_if.sink              wb,
	input  mips_pkg::reg_addr_t dbg_reg_addr,
	input  logic                ex_mem_read,
	input  mips_pkg::reg_addr_t ex_dest,
	output logic                stall,
	output logic                jump,
	output mips_pkg::pc_t       jump_target,
	output mips_pkg::data_t     dbg_reg_data,
	id_ex_if.source             out
);

	// instruction fields
	mips_pkg::op_t       op;
	mips_pkg::fn_t       funct;
	mips_pkg::reg_addr_t rs;
	mips_pkg::reg_addr_t rt;
	mips_pkg::reg_addr_t rd;
	mips_pkg::data_t     imm;

	// opcode class
	logic is_r;
	logic is_addi;
	logic is_lw;
	logic is_sw;
	logic is_beq;
	logic is_halt;
	logic fn_ok;
	logic uses_rs;
	logic uses_rt;

	mips_pkg::alu_op_t   alu_op;
	mips_pkg::reg_addr_t dest;
	logic                reg_write;
	logic                bubble;
	mips_pkg::data_t     rs_val;
	mips_pkg::data_t     rt_val;
	mips_pkg::data_t     rf [mips_pkg::num_regs];

	// r0 reads zero, a same-cycle write is bypassed
	function automatic mips_pkg::data_t rf_read(input mips_pkg::reg_addr_t a);
		if (a == '0)
			return '0;
		if (wb.reg_write && wb.dest == a)
			return wb.wb_data;
		return rf[a];
	endfunction

	assign op    = instr[31:26];
	assign rs    = instr[25:21];
	assign rt    = instr[20:16];
	assign rd    = instr[15:11];
	assign funct = instr[5:0];
	// sign extended immediate
	assign imm   = {{16{instr[15]}}, instr[15:0]};

	////////////////////////////////////////
	// decode
	////////////////////////////////////////

	// halt opcode 6'h3f matches no class below
	assign is_halt = instr == mips_pkg::halt_word;
	assign is_r    = op == mips_pkg::op_rtype;
	assign is_addi = op == mips_pkg::op_addi;
	assign is_lw   = op == mips_pkg::op_lw;
	assign is_sw   = op == mips_pkg::op_sw;
	assign is_beq  = op == mips_pkg::op_beq;
	assign jump    = op == mips_pkg::op_j;
	// j target field taken as a word index
	assign jump_target = instr[7:0];

	always_comb begin
		fn_ok  = 1'b1;
		alu_op = mips_pkg::alu_add;
		if (is_beq)
			alu_op = mips_pkg::alu_sub;
		else if (is_r) begin
			case (funct)
				mips_pkg::fn_addu: alu_op = mips_pkg::alu_add;
				mips_pkg::fn_subu: alu_op = mips_pkg::alu_sub;
				mips_pkg::fn_and:  alu_op = mips_pkg::alu_and;
				mips_pkg::fn_or:   alu_op = mips_pkg::alu_or;
				mips_pkg::fn_slt:  alu_op = mips_pkg::alu_slt;
				// unknown funct, incl. the zero nop, writes nothing
				default:           fn_ok  = 1'b0;
			endcase
		end
	end

	assign dest      = is_r ? rd : rt;
	// writes to r0 dropped here, so nothing downstream sees them
	assign reg_write = ((is_r && fn_ok) || is_addi || is_lw) && dest != '0;
	assign uses_rs   = is_r || is_addi || is_lw || is_sw || is_beq;
	assign uses_rt   = is_r || is_sw || is_beq;

	// load-use against the instruction now in ex
	assign stall = ex_mem_read && ex_dest != '0 &&
		((uses_rs && rs == ex_dest) || (uses_rt && rt == ex_dest));

	// stall or flush turns the id/ex entry into a bubble
	assign bubble = flush || stall;

	////////////////////////////////////////
	// register file
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < mips_pkg::num_regs; i++)
				rf[i] <= '0;
		end else if (wb.reg_write && wb.dest != '0) begin
			rf[wb.dest] <= wb.wb_data;
		end
	end

	always_comb begin
		rs_val       = rf_read(rs);
		rt_val       = rf_read(rt);
		dbg_reg_data = rf_read(dbg_reg_addr);
	end

	// id/ex controls
	always_ff @(posedge clk) begin
		if (!rst_n || bubble) begin
			out.dest       <= '0;
			out.mem_read   <= 1'b0;
			out.mem_write  <= 1'b0;
			out.reg_write  <= 1'b0;
			out.mem_to_reg <= 1'b0;
			out.is_branch  <= 1'b0;
			out.halt       <= 1'b0;
		end else if (!out.halt) begin
			out.dest       <= dest;
			out.mem_read   <= is_lw;
			out.mem_write  <= is_sw;
			out.reg_write  <= reg_write;
			out.mem_to_reg <= is_lw;
			out.is_branch  <= is_beq;
			out.halt       <= is_halt;
		end
	end

	// id/ex payload
	always_ff @(posedge clk) begin
		if (!out.halt) begin
			out.rs_val      <= rs_val;
			out.rt_val      <= rt_val;
			out.imm         <= imm;
			out.rs          <= rs;
			out.rt          <= rt;
			out.alu_op      <= alu_op;
			out.alu_src_imm <= is_addi || is_lw || is_sw;
			out.pc_plus4    <= pc_plus4;
		end
	end

	// decode gates r0 writes three stages upstream of wb
	assert property (@(posedge clk) disable iff (!rst_n) !(wb.reg_write && wb.dest == '0));

endmodule

//--- rtl/stage_if.sv
`timescale 1ns/1ps

module stage_if (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 debug_flag,
	input  mips_pkg::imem_addr_t imem_addr,
	input  mips_pkg::data_t      imem_data,
	input  logic                 imem_we,
	input  logic                 stall,
	input  logic                 jump,
	input  mips_pkg::pc_t        jump_target,
	input  logic                 branch_taken,
	input  mips_pkg::pc_t        branch_target,
	input  logic                 halt_seen,
	output mips_pkg::data_t      instr,
	output mips_pkg::pc_t        pc_plus4,
	output mips_pkg::pc_t        out_pc
);

	mips_pkg::data_t        imem [mips_pkg::len_imem];
	mips_pkg::fetch_state_t state;
	mips_pkg::pc_t          pc;
	mips_pkg::pc_t          next_pc;
	logic                   fetch_en;

	// debug write port, open only during the load phase
	always_ff @(posedge clk) begin
		if (state == mips_pkg::st_load && imem_we) begin
			imem[imem_addr] <= imem_data;
		end
	end

	// redirect priority: branch, jump, stall hold, increment
	always_comb begin
		if (branch_taken)
			next_pc = branch_target;
		else if (jump)
			next_pc = jump_target;
		else if (stall)
			next_pc = pc;
		else
			next_pc = pc + mips_pkg::pc_t'(1);
	end

	// halt in mem freezes fetch in the same cycle
	assign fetch_en = state == mips_pkg::st_run && !halt_seen;

	////////////////////////////////////////
	// fetch fsm and pc
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= mips_pkg::st_load;
			pc    <= '0;
		end else begin
			case (state)
				mips_pkg::st_load: begin
					// pc parked at 0 while loading
					pc <= '0;
					if (!debug_flag)
						state <= mips_pkg::st_run;
				end
				mips_pkg::st_run: begin
					if (halt_seen)
						state <= mips_pkg::st_halted;
					else
						pc <= next_pc;
				end
				mips_pkg::st_halted: state <= mips_pkg::st_halted;
				default: state <= mips_pkg::st_load;
			endcase
		end
	end

	// if/id register, zero word doubles as bubble
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			instr    <= '0;
			pc_plus4 <= '0;
		end else if (fetch_en) begin
			if (branch_taken || jump) begin
				instr <= '0;
			end else if (!stall) begin
				instr    <= imem[mips_pkg::imem_addr_t'(pc)];
				pc_plus4 <= pc + mips_pkg::pc_t'(1);
			end
		end
	end

	assign out_pc = pc;

endmodule

//--- rtl/stage_mem.sv
`timescale 1ns/1ps

module stage_mem (
	input  logic          clk,
	input  logic          rst_n,
	ex_mem_if.sink        in,
	mem_wb_if.source      out,
	output logic          branch_taken,
	output mips_pkg::pc_t branch_target,
	output logic          halt_seen,
	output logic          halt_flag
);

	mips_pkg::data_t             dmem [mips_pkg::len_dmem];
	logic [mips_pkg::dmem_aw-1:0] word_addr;
	mips_pkg::data_t             load_data;
	logic                        wb_halt;

	// branch resolved here, redirect goes straight to fetch
	assign branch_taken  = in.is_branch && in.zero;
	assign branch_target = in.branch_target;
	assign halt_seen     = in.halt;

	////////////////////////////////////////
	// data memory
	////////////////////////////////////////

	// byte address in, low two bits dropped
	assign word_addr = in.alu_result[mips_pkg::dmem_aw+1:2];
	assign load_data = dmem[word_addr];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < mips_pkg::len_dmem; i++)
				dmem[i] <= '0;
		end else if (in.mem_write) begin
			dmem[word_addr] <= in.store_val;
		end
	end

	// mem/wb, frozen once the halt word arrives
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out.reg_write <= 1'b0;
			wb_halt       <= 1'b0;
		end else if (!wb_halt) begin
			out.reg_write <= in.reg_write;
			wb_halt       <= in.halt;
		end
	end

	always_ff @(posedge clk) begin
		if (!wb_halt) begin
			out.dest    <= in.dest;
			out.wb_data <= in.mem_to_reg ? load_data : in.alu_result;
		end
	end

	// sticky until reset, one cycle behind the halt in wb
	always_ff @(posedge clk) begin
		if (!rst_n)
			halt_flag <= 1'b0;
		else if (wb_halt)
			halt_flag <= 1'b1;
	end

	// both come from one decoded opcode in id
	assert property (@(posedge clk) disable iff (!rst_n) !(in.mem_read && in.mem_write));

endmodule

//--- vlog.f
rtl/mips_pkg.sv
rtl/pipe_if.sv
rtl/stage_if.sv
rtl/stage_id.sv
rtl/stage_ex.sv
rtl/stage_mem.sv
rtl/mips_top.sv
bench/tb_clock.sv
bench/tb_checker.sv
bench/tb_mips.sv
